// File: verilog/mips_macros.svh
/*
  encodings for the MIPS32 subset handled by the core
  any other opcode or funct value decodes as a no-op
*/
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// ============================================================
// primary opcodes, instr[31:26]
// ============================================================
// all R-type ops share opcode zero
`define OP_RTYPE 6'b000000
// add immediate, sign-extended
`define OP_ADDI  6'b001000
// word load and store, base plus offset
`define OP_LW    6'b100011
`define OP_SW    6'b101011
// branch on equal
`define OP_BEQ   6'b000100
// jumps, 26-bit word index
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// ============================================================
// R-type function codes, instr[5:0]
// ============================================================
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
// signed compare
`define FN_SLT   6'b101010

// ============================================================
// misc
// ============================================================
// jal return address lands here
`define LINK_REG 5'd31
// data memory word index width, 128 words
`define DMEM_ADDR_W 7

`endif

// File: verilog/mipsPkg.sv
/*
  shared types for the single-cycle core
  data memory index width comes from the macros header
*/
`include "mips_macros.svh"

package mipsPkg;

  // ============================================================
  // basic widths
  // ============================================================

  // one data or address word
  typedef logic [31:0] wordT;

  // register number, 0 reads as zero
  typedef logic [4:0] regAddrT;

  // word index into data memory, byte offset dropped
  typedef logic [`DMEM_ADDR_W-1:0] dmemAddrT;

  // ============================================================
  // control selectors
  // ============================================================

  // ALU operation, codes follow the classic
  // four-bit MIPS ALU control values
  typedef enum logic [3:0] {
    ALU_AND = 4'b0000,
    ALU_OR  = 4'b0001,
    ALU_ADD = 4'b0010,
    ALU_SUB = 4'b0110,
    ALU_SLT = 4'b0111
  } aluCtrlT;

  // write-back source
  // WB_LINK is pc plus 4 for jal
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_LINK = 2'd2
  } wbSelT;

endpackage

// File: verilog/mipsDecode.sv
/*
  pure combinational decode, unknown encodings give no strobes
  regWrite is already cleared for a destination of register 0
*/
`timescale 1ns/10ps
`include "mips_macros.svh"

module mipsDecode (
  input  mipsPkg::wordT    instr,
  output mipsPkg::regAddrT rsAddr,
  output mipsPkg::regAddrT rtAddr,
  output mipsPkg::regAddrT destAddr,
  output mipsPkg::wordT    immValue,
  output logic             useImm,
  output mipsPkg::aluCtrlT aluCtrl,
  output mipsPkg::wbSelT   wbSel,
  output logic             regWrite,
  output logic             memWrite,
  output logic             isBranch,
  output logic             isJump,
  output logic [25:0]      jumpIndex
);
  import mipsPkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;
  logic       writeIntent;

  // instruction fields
  assign opcode    = instr[31:26];
  assign funct     = instr[5:0];
  assign rsAddr    = instr[25:21];
  assign rtAddr    = instr[20:16];
  assign jumpIndex = instr[25:0];

  // sign extension of the 16-bit immediate
  assign immValue = {{16{instr[15]}}, instr[15:0]};

  // ============================================================
  // main decode, ALU control folded in
  // ============================================================
  always_comb begin
    // defaults describe a no-op
    useImm      = 1'b0;
    aluCtrl     = ALU_ADD;
    wbSel       = WB_ALU;
    writeIntent = 1'b0;
    memWrite    = 1'b0;
    isBranch    = 1'b0;
    isJump      = 1'b0;
    destAddr    = instr[20:16];
    case (opcode)
      `OP_RTYPE: begin
        destAddr    = instr[15:11];
        writeIntent = 1'b1;
        case (funct)
          `FN_ADD: aluCtrl = ALU_ADD;
          `FN_SUB: aluCtrl = ALU_SUB;
          `FN_AND: aluCtrl = ALU_AND;
          `FN_OR:  aluCtrl = ALU_OR;
          `FN_SLT: aluCtrl = ALU_SLT;
          // unsupported funct, no write
          default: writeIntent = 1'b0;
        endcase
      end
      `OP_ADDI: begin
        useImm      = 1'b1;
        writeIntent = 1'b1;
      end
      `OP_LW: begin
        // address is base plus offset
        useImm      = 1'b1;
        wbSel       = WB_MEM;
        writeIntent = 1'b1;
      end
      `OP_SW: begin
        useImm   = 1'b1;
        memWrite = 1'b1;
      end
      `OP_BEQ: begin
        // equality comes from execute, ALU result unused
        aluCtrl  = ALU_SUB;
        isBranch = 1'b1;
      end
      `OP_J: isJump = 1'b1;
      `OP_JAL: begin
        isJump      = 1'b1;
        destAddr    = `LINK_REG;
        wbSel       = WB_LINK;
        writeIntent = 1'b1;
      end
      default: ;
    endcase
  end

  // never strobe a write to register 0
  assign regWrite = writeIntent && (destAddr != '0);

endmodule

// File: verilog/mipsRegFile.sv
/*
  registers 1..31 only, register 0 is hard-wired to zero
  contents are undefined after reset until written
*/
`timescale 1ns/10ps

module mipsRegFile (
  input  logic             clk,
  input  logic             we,
  input  mipsPkg::regAddrT rAddrA,
  input  mipsPkg::regAddrT rAddrB,
  input  mipsPkg::regAddrT wAddr,
  input  mipsPkg::wordT    wData,
  output mipsPkg::wordT    rDataA,
  output mipsPkg::wordT    rDataB
);
  import mipsPkg::*;

  // storage, no entry for register 0
  wordT regs [1:31];

  // ============================================================
  // write port
  // ============================================================
  // address 0 dropped here as well, the array has no slot for it
  always_ff @(posedge clk) begin
    if (we && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  // ============================================================
  // read ports
  // ============================================================
  // combinational, no bypass of the write in the same cycle
  always_comb begin
    rDataA = '0;
    rDataB = '0;
    if (rAddrA != '0) begin
      rDataA = regs[rAddrA];
    end
    if (rAddrB != '0) begin
      rDataB = regs[rAddrB];
    end
  end

endmodule

// File: verilog/mipsExecute.sv
/*
  combinational ALU, slt is signed only
  operandsEqual compares rs and rt whatever the operation
*/
`timescale 1ns/10ps

module mipsExecute (
  input  mipsPkg::wordT    rsData,
  input  mipsPkg::wordT    rtData,
  input  mipsPkg::wordT    immValue,
  input  logic             useImm,
  input  mipsPkg::aluCtrlT aluCtrl,
  output mipsPkg::wordT    aluResult,
  output logic             operandsEqual
);
  import mipsPkg::*;

  wordT opB;
  logic sltFlag;

  // ============================================================
  // operand selection
  // ============================================================
  // immediate for addi, lw and sw
  assign opB = useImm ? immValue : rtData;

  // signed compare for slt
  assign sltFlag = $signed(rsData) < $signed(opB);

  // ============================================================
  // ALU
  // ============================================================
  always_comb begin
    case (aluCtrl)
      ALU_AND: begin
        aluResult = rsData & opB;
      end
      ALU_OR: begin
        aluResult = rsData | opB;
      end
      ALU_ADD: begin
        // also the load/store address
        aluResult = rsData + opB;
      end
      ALU_SUB: begin
        aluResult = rsData - opB;
      end
      ALU_SLT: begin
        aluResult = {31'd0, sltFlag};
      end
      default: begin
        aluResult = '0;
      end
    endcase
  end

  // ============================================================
  // branch compare
  // ============================================================
  // independent of aluCtrl, so branch decision lives
  // entirely in the result stage
  assign operandsEqual = (rsData == rtData);

endmodule

// File: verilog/mipsResult.sv
/*
  pc register with synchronous reset to 0, no delay slots
  low two bits of the data address are ignored
*/
`timescale 1ns/10ps
`include "mips_macros.svh"

module mipsResult (
  input  logic             clk,
  input  logic             rst,
  input  mipsPkg::wordT    aluResult,
  input  mipsPkg::wordT    rtData,
  input  mipsPkg::wordT    immValue,
  input  mipsPkg::wordT    dmemRData,
  input  logic             operandsEqual,
  input  logic             isBranch,
  input  logic             isJump,
  input  logic             regWrite,
  input  logic             memWrite,
  input  logic [25:0]      jumpIndex,
  input  mipsPkg::wbSelT   wbSel,
  input  mipsPkg::regAddrT destAddr,
  output mipsPkg::wordT    pc,
  output mipsPkg::dmemAddrT dmemAddr,
  output mipsPkg::wordT    dmemWData,
  output logic             dmemWe,
  output logic             regWe,
  output mipsPkg::regAddrT regWAddr,
  output mipsPkg::wordT    regWData
);
  import mipsPkg::*;

  wordT pcPlus4;
  wordT branchTarget;
  wordT jumpTarget;
  wordT nextPc;

  // ============================================================
  // next pc
  // ============================================================
  assign pcPlus4      = pc + 32'd4;
  // offset counts words
  assign branchTarget = pcPlus4 + {immValue[29:0], 2'b00};
  // region bits come from pc plus 4
  assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};

  always_comb begin
    if (isJump) begin
      nextPc = jumpTarget;
    end else if (isBranch && operandsEqual) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // one instruction per clock
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // ============================================================
  // data memory port
  // ============================================================
  // word index, byte offset dropped
  assign dmemAddr  = aluResult[`DMEM_ADDR_W+1:2];
  assign dmemWData = rtData;
  assign dmemWe    = memWrite && !rst;

  // ============================================================
  // write-back
  // ============================================================
  assign regWe    = regWrite && !rst;
  assign regWAddr = destAddr;

  always_comb begin
    case (wbSel)
      WB_MEM:  regWData = dmemRData;
      // jal return address
      WB_LINK: regWData = pcPlus4;
      default: regWData = aluResult;
    endcase
  end

endmodule

// File: verilog/mipsCore.sv
/*
  single-cycle core, both memories must answer in the same cycle
  regWe/regWAddr/regWData mirror the register file write port
*/
`timescale 1ns/10ps

module mipsCore (
  input  logic              clk,
  input  logic              rst,
  input  mipsPkg::wordT     imemData,
  input  mipsPkg::wordT     dmemRData,
  output mipsPkg::wordT     imemAddr,
  output mipsPkg::wordT     dmemWData,
  output mipsPkg::wordT     regWData,
  output mipsPkg::dmemAddrT dmemAddr,
  output logic              dmemWe,
  output logic              regWe,
  output mipsPkg::regAddrT  regWAddr
);
  import mipsPkg::*;

  // ============================================================
  // decode to the rest
  // ============================================================
  regAddrT     rsAddr;
  regAddrT     rtAddr;
  regAddrT     destAddr;
  wordT        immValue;
  logic        useImm;
  aluCtrlT     aluCtrl;
  wbSelT       wbSel;
  logic        regWrite;
  logic        memWrite;
  logic        isBranch;
  logic        isJump;
  logic [25:0] jumpIndex;

  // register file and execute outputs
  wordT rsData;
  wordT rtData;
  wordT aluResult;
  logic operandsEqual;

  mipsDecode decode_i (
    .instr     (imemData),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .destAddr  (destAddr),
    .immValue  (immValue),
    .useImm    (useImm),
    .aluCtrl   (aluCtrl),
    .wbSel     (wbSel),
    .regWrite  (regWrite),
    .memWrite  (memWrite),
    .isBranch  (isBranch),
    .isJump    (isJump),
    .jumpIndex (jumpIndex)
  );

  // write port fed straight from the result stage
  mipsRegFile regFile_i (
    .clk    (clk),
    .we     (regWe),
    .rAddrA (rsAddr),
    .rAddrB (rtAddr),
    .wAddr  (regWAddr),
    .wData  (regWData),
    .rDataA (rsData),
    .rDataB (rtData)
  );

  mipsExecute execute_i (
    .rsData        (rsData),
    .rtData        (rtData),
    .immValue      (immValue),
    .useImm        (useImm),
    .aluCtrl       (aluCtrl),
    .aluResult     (aluResult),
    .operandsEqual (operandsEqual)
  );

  // pc goes straight out as the fetch address
  mipsResult result_i (
    .clk           (clk),
    .rst           (rst),
    .aluResult     (aluResult),
    .rtData        (rtData),
    .immValue      (immValue),
    .dmemRData     (dmemRData),
    .operandsEqual (operandsEqual),
    .isBranch      (isBranch),
    .isJump        (isJump),
    .regWrite      (regWrite),
    .memWrite      (memWrite),
    .jumpIndex     (jumpIndex),
    .wbSel         (wbSel),
    .destAddr      (destAddr),
    .pc            (imemAddr),
    .dmemAddr      (dmemAddr),
    .dmemWData     (dmemWData),
    .dmemWe        (dmemWe),
    .regWe         (regWe),
    .regWAddr      (regWAddr),
    .regWData      (regWData)
  );

endmodule

// File: test/mipsCore_assertions.sv
/*
  bound into every mipsCore instance
  all properties sampled on the rising clock edge
*/
`timescale 1ns/10ps

module mipsCoreAssertions (
  input logic             clk,
  input logic             rst,
  input logic             dmemWe,
  input logic             regWe,
  input mipsPkg::regAddrT regWAddr,
  input mipsPkg::wordT    imemAddr
);

  // ============================================================
  // strobes and fetch address
  // ============================================================
  // both strobes gated off by reset
  strobesQuietInReset: assert property (@(posedge clk) rst |-> (!dmemWe && !regWe))
    else $error("write strobe high during reset");

  // decode drops writes aimed at register 0
  regZeroNeverWritten: assert property (@(posedge clk) regWe |-> (regWAddr != 5'd0))
    else $error("register write strobe aimed at register 0");

  // pc only moves in whole words
  fetchAligned: assert property (@(posedge clk) !rst |-> (imemAddr[1:0] == 2'b00))
    else $error("fetch address %h not word aligned", imemAddr);

endmodule

bind mipsCore mipsCoreAssertions assertions_i (
  .clk      (clk),
  .rst      (rst),
  .dmemWe   (dmemWe),
  .regWe    (regWe),
  .regWAddr (regWAddr),
  .imemAddr (imemAddr)
);

// File: test/mipsCoreTb.sv
/*
  random programs checked each cycle against an ISA model
  both memories live here and answer combinationally
*/
`timescale 1ns/10ps
`include "mips_macros.svh"

module mipsCoreTb;
  import mipsPkg::*;

  // ============================================================
  // run sizes
  // ============================================================
  localparam int NUM_TESTS      = 6;
  localparam int TEST_CYCLES    = 300;
  localparam int RESET_CYCLES   = 5;
  // mid-program reset in the last test
  localparam int RESET_AT       = 150;
  // seed addi words, then random body, last word jumps to itself
  localparam int SEED_WORDS     = 31;
  localparam int PROG_LAST      = 199;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (TEST_CYCLES + RESET_CYCLES) + 100;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  wordT     imemData;
  wordT     dmemRData;
  wordT     imemAddr;
  wordT     dmemWData;
  wordT     regWData;
  dmemAddrT dmemAddr;
  logic     dmemWe;
  logic     regWe;
  regAddrT  regWAddr;

  // memories seen by the DUT
  wordT imem [0:255];
  wordT dmem [0:127];

  // reference model state
  wordT mRegs [0:31];
  wordT mDmem [0:127];
  wordT mPc;

  integer seed = 32'h4d87_c504;
  int errCount = 0;
  int checkCount = 0;
  int testsFailed = 0;
  int cycleCount = 0;

  always #10 clk = ~clk;

  assign imemData  = imem[imemAddr[9:2]];
  assign dmemRData = dmem[dmemAddr];

  mipsCore mipsCore_i (
    .clk       (clk),
    .rst       (rst),
    .imemData  (imemData),
    .dmemRData (dmemRData),
    .imemAddr  (imemAddr),
    .dmemWData (dmemWData),
    .regWData  (regWData),
    .dmemAddr  (dmemAddr),
    .dmemWe    (dmemWe),
    .regWe     (regWe),
    .regWAddr  (regWAddr)
  );

  // hard stop in case a test never returns
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycleCount);
      $display("Test failed");
      $finish;
    end
  end

  // ============================================================
  // random program generation
  // ============================================================
  function automatic int randBelow(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // every data word differs, tagged with its full index
  function automatic wordT fillWord(input int i);
    return 32'h6c3a_0000 ^ (32'(i) * 32'h0001_0101);
  endfunction

  function automatic string className(input int kind);
    case (kind)
      0: return "alu";
      1: return "load/store";
      2: return "branch";
      3: return "jump";
      4: return "reg0/unknown";
      default: return "mid-reset";
    endcase
  endfunction

  function automatic wordT genInstr(input int kind, input int idx);
    regAddrT    rs;
    regAddrT    rt;
    regAddrT    rd;
    logic [5:0] fn;
    logic [15:0] imm;
    int         target;
    wordT       w;
    rs  = regAddrT'(randBelow(32));
    rt  = regAddrT'(randBelow(32));
    rd  = regAddrT'(1 + randBelow(31));
    imm = 16'(randBelow(65536));
    case (randBelow(5))
      0: fn = `FN_ADD;
      1: fn = `FN_SUB;
      2: fn = `FN_AND;
      3: fn = `FN_OR;
      default: fn = `FN_SLT;
    endcase
    // mixed programs pick a class per word
    if (kind == 5) kind = randBelow(4);
    // some plain ALU work in most classes
    if (kind != 4 && randBelow(3) == 0) kind = 0;
    case (kind)
      1: begin
        // small index range so loads often hit stored words
        imm = 16'(randBelow(16) * 4 + randBelow(4));
        w = {(randBelow(2) == 0) ? `OP_SW : `OP_LW, 5'd0, rt, imm};
      end
      2: begin
        if (randBelow(2) == 0) rt = rs;
        // loops back only on distinct registers
        if (rt != rs && randBelow(4) == 0) begin
          target = SEED_WORDS + randBelow(idx - SEED_WORDS + 1);
        end else begin
          target = idx + 1 + randBelow(PROG_LAST - idx);
        end
        w = {`OP_BEQ, rs, rt, 16'(target - idx - 1)};
      end
      3: begin
        // forward only, a jump back would spin for ever
        target = idx + 1 + randBelow(PROG_LAST - idx);
        w = {(randBelow(2) == 0) ? `OP_J : `OP_JAL, 26'(target)};
      end
      4: begin
        case (randBelow(6))
          0: w = {`OP_RTYPE, rs, rt, 5'd0, 5'd0, fn};
          1: w = {`OP_ADDI, rs, 5'd0, imm};
          2: w = {`OP_RTYPE, 5'd0, rt, rd, 5'd0, fn};
          3: w = {`OP_ADDI, 5'd0, rd, imm};
          // ori, outside the subset
          4: w = {6'b001101, rs, rd, imm};
          // sll, unsupported funct
          default: w = {`OP_RTYPE, rs, rt, rd, 5'(randBelow(32)), 6'b000000};
        endcase
      end
      default: begin
        if (randBelow(6) == 0) begin
          w = {`OP_ADDI, rs, rd, imm};
        end else begin
          w = {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
        end
      end
    endcase
    return w;
  endfunction

  task automatic buildProgram(input int kind);
    // unused words hold unknown opcodes tagged with their index
    for (int i = 0; i < 256; i++) begin
      imem[i] = {6'b111111, 26'(i)};
    end
    for (int i = 1; i <= SEED_WORDS; i++) begin
      imem[i - 1] = {`OP_ADDI, 5'd0, 5'(i), 16'(randBelow(65536))};
    end
    for (int i = SEED_WORDS; i < PROG_LAST; i++) begin
      imem[i] = genInstr(kind, i);
    end
    imem[PROG_LAST] = {`OP_J, 26'(PROG_LAST)};
    for (int i = 0; i < 128; i++) begin
      dmem[i] <= fillWord(i);
      mDmem[i] = fillWord(i);
    end
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
    end
    mPc = '0;
  endtask

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic checkPc(input wordT expPc);
    checkCount++;
    if (imemAddr !== expPc) begin
      errCount++;
      $display("** Error at %0t: pc %h, expected %h", $time, imemAddr, expPc);
    end
  endtask

  task automatic checkRegWrite(input regAddrT expAddr, input wordT expData);
    checkCount++;
    if (regWAddr !== expAddr || regWData !== expData) begin
      errCount++;
      $display("** Error at %0t: register write r%0d = %h, expected r%0d = %h",
               $time, regWAddr, regWData, expAddr, expData);
    end
  endtask

  task automatic checkMemWrite(input dmemAddrT expAddr, input wordT expData);
    checkCount++;
    if (dmemAddr !== expAddr || dmemWData !== expData) begin
      errCount++;
      $display("** Error at %0t: memory write [%0d] = %h, expected [%0d] = %h",
               $time, dmemAddr, dmemWData, expAddr, expData);
    end
  endtask

  task automatic reportStrobe(input string what);
    errCount++;
    $display("at %0t: %s", $time, what);
  endtask

  // ============================================================
  // reference model, one instruction per call
  // ============================================================
  task automatic modelAndCompare();
    wordT    instr;
    wordT    a;
    wordT    b;
    wordT    imm;
    wordT    ea;
    wordT    wd;
    wordT    pcNext;
    regAddrT wa;
    logic    wr;
    logic    mw;
    instr  = imem[mPc[9:2]];
    a      = mRegs[instr[25:21]];
    b      = mRegs[instr[20:16]];
    imm    = {{16{instr[15]}}, instr[15:0]};
    ea     = a + imm;
    pcNext = mPc + 32'd4;
    wa     = instr[20:16];
    wd     = ea;
    wr     = 1'b0;
    mw     = 1'b0;
    case (instr[31:26])
      `OP_RTYPE: begin
        wa = instr[15:11];
        wr = 1'b1;
        case (instr[5:0])
          `FN_ADD: wd = a + b;
          `FN_SUB: wd = a - b;
          `FN_AND: wd = a & b;
          `FN_OR:  wd = a | b;
          `FN_SLT: wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: wr = 1'b0;
        endcase
      end
      `OP_ADDI: wr = 1'b1;
      `OP_LW: begin
        wr = 1'b1;
        wd = mDmem[ea[`DMEM_ADDR_W+1:2]];
      end
      `OP_SW: mw = 1'b1;
      `OP_BEQ: begin
        if (a == b) pcNext = mPc + 32'd4 + (imm << 2);
      end
      `OP_J: pcNext = {pcNext[31:28], instr[25:0], 2'b00};
      `OP_JAL: begin
        pcNext = {pcNext[31:28], instr[25:0], 2'b00};
        wa     = `LINK_REG;
        wd     = mPc + 32'd4;
        wr     = 1'b1;
      end
      default: ;
    endcase
    // register 0 never takes a write
    if (wa == 5'd0) wr = 1'b0;

    checkPc(mPc);
    if (wr && !regWe) begin
      reportStrobe($sformatf("register write to r%0d missing", wa));
    end else if (!wr && regWe) begin
      reportStrobe($sformatf("unexpected register write to r%0d", regWAddr));
    end else if (wr) begin
      checkRegWrite(wa, wd);
    end
    if (mw && !dmemWe) begin
      reportStrobe("memory write missing");
    end else if (!mw && dmemWe) begin
      reportStrobe($sformatf("unexpected memory write to index %0d", dmemAddr));
    end else if (mw) begin
      checkMemWrite(ea[`DMEM_ADDR_W+1:2], b);
    end

    // commit
    if (wr) mRegs[wa] = wd;
    if (mw) mDmem[ea[`DMEM_ADDR_W+1:2]] = b;
    mPc = pcNext;
  endtask

  // ============================================================
  // test sequence
  // ============================================================
  task automatic runTest(input int kind);
    int       errsBefore;
    logic     pendWe;
    dmemAddrT pendAddr;
    wordT     pendData;
    errsBefore = errCount;
    rst <= 1'b1;
    @(negedge clk);
    buildProgram(kind);
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      // outputs settled mid-cycle
      @(negedge clk);
      pendWe   = dmemWe;
      pendAddr = dmemAddr;
      pendData = dmemWData;
      if (rst) begin
        if (dmemWe || regWe) reportStrobe("write strobe high while reset is asserted");
        // first fetch afterwards at address 0
        mPc = '0;
      end else begin
        modelAndCompare();
      end
      @(posedge clk);
      if (pendWe) dmem[pendAddr] <= pendData;
      if (kind == 5 && cyc == RESET_AT) begin
        rst <= 1'b1;
      end else if (kind == 5 && cyc == RESET_AT + RESET_CYCLES) begin
        rst <= 1'b0;
      end
    end
    if (errCount != errsBefore) testsFailed++;
    $display("test %0d %s: %s, %0d errors", kind, className(kind),
             (errCount == errsBefore) ? "ok" : "FAILED", errCount - errsBefore);
  endtask

  initial begin
    for (int t = 0; t < NUM_TESTS; t++) begin
      runTest(t);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             NUM_TESTS, testsFailed, checkCount, errCount);
    if (errCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: mipsCore.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/mipsDecode.sv
verilog/mipsRegFile.sv
verilog/mipsExecute.sv
verilog/mipsResult.sv
verilog/mipsCore.sv
test/mipsCore_assertions.sv
test/mipsCoreTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mipsCoreTb
FILELIST = mipsCore.f
LOG      = sim.log
FAIL_MSG = Test failed
PASS_MSG = Test completed successfully

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
